// File: common/muldiv_pkg.sv
//--------------------------------------------------------------------
// Shared definitions for the RV32M multiply/divide unit.
// Holds the widths, the funct3 codes, the decoded operation, the
// per-cycle steering strobes and the controller state encoding.
// Compile before any module of the unit.
//--------------------------------------------------------------------
package muldiv_pkg;

    //----------------------------------------------------------------
    // Widths and iteration count
    //----------------------------------------------------------------
    localparam int XLEN      = 32;          // Operand and result width
    localparam int ACC_W     = 2 * XLEN;    // Product or rem/quot pair
    localparam int DIV_ITERS = 32;          // One quotient bit per step
    localparam int CNT_W     = 5;           // Holds DIV_ITERS-1

    //----------------------------------------------------------------
    // M-extension funct3 codes
    //----------------------------------------------------------------
    localparam logic [2:0] F3_MUL    = 3'd0;
    localparam logic [2:0] F3_MULH   = 3'd1;
    localparam logic [2:0] F3_MULHSU = 3'd2;
    localparam logic [2:0] F3_MULHU  = 3'd3;
    localparam logic [2:0] F3_DIV    = 3'd4;
    localparam logic [2:0] F3_DIVU   = 3'd5;
    localparam logic [2:0] F3_REM    = 3'd6;
    localparam logic [2:0] F3_REMU   = 3'd7;

    //----------------------------------------------------------------
    // Decoded operation
    //----------------------------------------------------------------
    typedef struct packed {
        logic is_div;       // Divide family
        logic is_high;      // Upper product half
        logic src1_signed;  // Multiplicand is signed
        logic src2_signed;  // Multiplier is signed
        logic div_signed;   // DIV or REM
        logic is_rem;       // Return the remainder
    } muldiv_op_t;

    //----------------------------------------------------------------
    // Steering strobes, at most one set per cycle
    //----------------------------------------------------------------
    typedef struct packed {
        logic capture;      // Latch operation and operands
        logic mul_load;     // Write the product
        logic div_check;    // Nonzero divisor, set up the loop
        logic div_zero;     // Divisor is zero
        logic div_step;     // One shift-subtract iteration
        logic ret;          // Result on the output
    } muldiv_step_t;

    //----------------------------------------------------------------
    // Controller states
    //----------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_MUL   = 3'd1,
        ST_CHECK = 3'd2,
        ST_EXEC  = 3'd3,
        ST_RET   = 3'd4
    } state_t;

    // The multiplier returns to ST_IDLE via ST_RET like the divider,
    // so every operation ends with exactly one ST_RET cycle.

endpackage

// File: hw/muldiv/muldiv_ctrl.sv
//--------------------------------------------------------------------
// Sequencer of the multiply/divide unit.
// Decodes funct3 into operation flags and walks the multiply path
// (capture, product, return) or the restoring divide path
// (capture, check, 32 steps, return), raising one strobe per cycle.
//--------------------------------------------------------------------
`timescale 1ns/10ps

module muldiv_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic [2:0]               funct3_i,
    input  logic                     divisor_zero_i,
    input  logic                     last_i,
    output muldiv_pkg::muldiv_op_t   op_o,
    output muldiv_pkg::muldiv_step_t step_o,
    output logic                     busy_o,
    output logic                     done_o
);
    import muldiv_pkg::*;

    state_t state_q;
    state_t state_d;
    logic   start_ok;

    assign start_ok = (state_q == ST_IDLE) && start_i;  // Starts while busy are dropped

    //----------------------------------------------------------------
    // funct3 decode
    //----------------------------------------------------------------
    always_comb begin
        op_o = '0;
        case (funct3_i)
            F3_MUL:    op_o.is_high = 1'b0;
            F3_MULH: begin
                op_o.is_high     = 1'b1;
                op_o.src1_signed = 1'b1;
                op_o.src2_signed = 1'b1;
            end
            F3_MULHSU: begin
                op_o.is_high     = 1'b1;
                op_o.src1_signed = 1'b1;
            end
            F3_MULHU:  op_o.is_high = 1'b1;
            F3_DIV: begin
                op_o.is_div     = 1'b1;
                op_o.div_signed = 1'b1;
            end
            F3_DIVU:   op_o.is_div = 1'b1;
            F3_REM: begin
                op_o.is_div     = 1'b1;
                op_o.div_signed = 1'b1;
                op_o.is_rem     = 1'b1;
            end
            F3_REMU: begin
                op_o.is_div = 1'b1;
                op_o.is_rem = 1'b1;
            end
            default:   op_o = '0;
        endcase
    end

    //----------------------------------------------------------------
    // State machine
    //----------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (start_i) state_d = funct3_i[2] ? ST_CHECK : ST_MUL;
            ST_MUL:   state_d = ST_RET;
            ST_CHECK: state_d = divisor_zero_i ? ST_RET : ST_EXEC;  // x/0 skips the loop
            ST_EXEC:  if (last_i) state_d = ST_RET;
            ST_RET:   state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Strobes
    always_comb begin
        step_o           = '0;
        step_o.capture   = start_ok;
        step_o.mul_load  = (state_q == ST_MUL);
        step_o.div_check = (state_q == ST_CHECK) && !divisor_zero_i;
        step_o.div_zero  = (state_q == ST_CHECK) && divisor_zero_i;
        step_o.div_step  = (state_q == ST_EXEC);
        step_o.ret       = (state_q == ST_RET);
    end

    assign busy_o = (state_q != ST_IDLE);
    assign done_o = (state_q == ST_RET);

endmodule

// File: hw/muldiv/iter_counter.sv
//--------------------------------------------------------------------
// Iteration counter for the restoring divider.
// Loaded at the check step and counted down once per divide step.
// last_o marks the final iteration.
//--------------------------------------------------------------------
`timescale 1ns/10ps

module iter_counter (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  muldiv_pkg::muldiv_step_t step_i,
    output logic                     last_o
);
    import muldiv_pkg::*;

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (step_i.div_check) begin
            cnt_q <= CNT_W'(DIV_ITERS - 1);     // 31 more steps after the first
        end else if (step_i.div_step) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Only meaningful inside the loop
    assign last_o = step_i.div_step && (cnt_q == '0);

endmodule

// File: hw/muldiv/operand_regs.sv
//--------------------------------------------------------------------
// Operand and operation registers of the multiply/divide unit.
// Latches the operation and both operands on capture, then swaps
// the operands for their magnitudes at the divide check step.
// Provides sign-extended multiply operands and the result sign flags.
//--------------------------------------------------------------------
`timescale 1ns/10ps

module operand_regs (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  muldiv_pkg::muldiv_step_t      step_i,
    input  muldiv_pkg::muldiv_op_t        op_i,
    input  logic [muldiv_pkg::XLEN-1:0]   src1_i,
    input  logic [muldiv_pkg::XLEN-1:0]   src2_i,
    output muldiv_pkg::muldiv_op_t        op_o,
    output logic signed [muldiv_pkg::XLEN:0] mcand_o,
    output logic signed [muldiv_pkg::XLEN:0] mplier_o,
    output logic [muldiv_pkg::XLEN-1:0]   dividend_mag_o,
    output logic [muldiv_pkg::XLEN-1:0]   divisor_mag_o,
    output logic                          divisor_zero_o,
    output logic                          quot_neg_o,
    output logic                          rem_neg_o
);
    import muldiv_pkg::*;

    muldiv_op_t      op_q;
    logic [XLEN-1:0] src1_q;
    logic [XLEN-1:0] src2_q;
    logic            src1_neg_q;    // Dividend still in two's complement
    logic            src2_neg_q;
    logic            quot_neg_q;
    logic            rem_neg_q;

    //----------------------------------------------------------------
    // Operation and sign flags
    //----------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_q       <= '0;
            src1_neg_q <= 1'b0;
            src2_neg_q <= 1'b0;
            quot_neg_q <= 1'b0;
            rem_neg_q  <= 1'b0;
        end else if (step_i.capture) begin
            op_q       <= op_i;
            src1_neg_q <= op_i.div_signed && src1_i[XLEN-1];
            src2_neg_q <= op_i.div_signed && src2_i[XLEN-1];
            quot_neg_q <= op_i.div_signed && (src1_i[XLEN-1] ^ src2_i[XLEN-1]);
            rem_neg_q  <= op_i.div_signed && src1_i[XLEN-1];  // Follows the dividend
        end else if (step_i.div_check) begin
            src1_neg_q <= 1'b0;     // Registers hold magnitudes from now on
            src2_neg_q <= 1'b0;
        end else if (step_i.div_zero) begin
            quot_neg_q <= 1'b0;
            rem_neg_q  <= 1'b0;
        end
    end

    // Operand payload
    always_ff @(posedge clk_i) begin
        if (step_i.capture) begin
            src1_q <= src1_i;
            src2_q <= src2_i;
        end else if (step_i.div_check) begin
            src1_q <= dividend_mag_o;
            src2_q <= divisor_mag_o;
        end
    end

    assign dividend_mag_o = src1_neg_q ? -src1_q : src1_q;
    assign divisor_mag_o  = src2_neg_q ? -src2_q : src2_q;
    assign divisor_zero_o = (src2_q == '0);

    assign mcand_o  = {op_q.src1_signed && src1_q[XLEN-1], src1_q};
    assign mplier_o = {op_q.src2_signed && src2_q[XLEN-1], src2_q};

    assign op_o       = op_q;
    assign quot_neg_o = quot_neg_q;
    assign rem_neg_o  = rem_neg_q;

endmodule

// File: hw/muldiv/muldiv_acc.sv
//--------------------------------------------------------------------
// Shared 64-bit accumulator of the multiply/divide unit.
// Holds the full product for multiplies, or the remainder (upper
// half) and quotient (lower half) pair for the restoring divider.
// During the return cycle it picks and sign-corrects the result.
//--------------------------------------------------------------------
`timescale 1ns/10ps

module muldiv_acc (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  muldiv_pkg::muldiv_step_t         step_i,
    input  muldiv_pkg::muldiv_op_t           op_i,
    input  logic signed [muldiv_pkg::XLEN:0] mcand_i,
    input  logic signed [muldiv_pkg::XLEN:0] mplier_i,
    input  logic [muldiv_pkg::XLEN-1:0]      dividend_mag_i,
    input  logic [muldiv_pkg::XLEN-1:0]      divisor_mag_i,
    input  logic                             quot_neg_i,
    input  logic                             rem_neg_i,
    output logic [muldiv_pkg::XLEN-1:0]      rslt_o
);
    import muldiv_pkg::*;

    logic [ACC_W-1:0]        acc_q;
    logic [XLEN-1:0]         rem;
    logic [XLEN-1:0]         quot;
    logic [XLEN:0]           shifted;   // Partial remainder with next dividend bit
    logic [XLEN:0]           diff;
    logic                    fits;
    logic signed [ACC_W+1:0] prod;
    logic [XLEN-1:0]         rslt_mag;
    logic                    rslt_neg;

    assign rem  = acc_q[ACC_W-1:XLEN];
    assign quot = acc_q[XLEN-1:0];

    //----------------------------------------------------------------
    // Datapath
    //----------------------------------------------------------------
    assign prod    = mcand_i * mplier_i;                // 33x33 signed
    assign shifted = {rem, quot[XLEN-1]};
    assign diff    = shifted - {1'b0, divisor_mag_i};
    assign fits    = (shifted >= {1'b0, divisor_mag_i});  // Quotient bit

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            acc_q <= '0;
        end else if (step_i.mul_load) begin
            acc_q <= prod[ACC_W-1:0];
        end else if (step_i.div_check) begin
            acc_q <= {{XLEN{1'b0}}, dividend_mag_i};
        end else if (step_i.div_zero) begin
            // Remainder is the dividend as written, quotient all ones
            acc_q <= {mcand_i[XLEN-1:0], {XLEN{1'b1}}};
        end else if (step_i.div_step) begin
            acc_q <= {fits ? diff[XLEN-1:0] : shifted[XLEN-1:0],
                      quot[XLEN-2:0], fits};
        end
    end

    //----------------------------------------------------------------
    // Result select and sign fix-up
    //----------------------------------------------------------------
    always_comb begin
        if (!op_i.is_div) begin
            rslt_mag = op_i.is_high ? acc_q[ACC_W-1:XLEN] : acc_q[XLEN-1:0];
            rslt_neg = 1'b0;                // Product already signed
        end else if (op_i.is_rem) begin
            rslt_mag = rem;
            rslt_neg = rem_neg_i;
        end else begin
            rslt_mag = quot;
            rslt_neg = quot_neg_i;
        end
    end

    assign rslt_o = step_i.ret ? (rslt_neg ? -rslt_mag : rslt_mag) : '0;  // Zero when idle

endmodule

// File: hw/muldiv/muldiv_unit.sv
//--------------------------------------------------------------------
// Top level of the RV32M multiply/divide unit.
// Pulse start_i with funct3_i and both operands while busy_o is low.
// The result is on rslt_o for the single cycle in which done_o is high.
//--------------------------------------------------------------------
`timescale 1ns/10ps

module muldiv_unit (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  logic [2:0]                  funct3_i,
    input  logic [muldiv_pkg::XLEN-1:0] src1_i,
    input  logic [muldiv_pkg::XLEN-1:0] src2_i,
    output logic                        busy_o,
    output logic                        done_o,
    output logic [muldiv_pkg::XLEN-1:0] rslt_o
);
    import muldiv_pkg::*;

    muldiv_op_t        op_dec;          // Decoded from funct3_i
    muldiv_op_t        op_reg;          // Held for the whole operation
    muldiv_step_t      step;
    logic              last;
    logic              divisor_zero;
    logic signed [XLEN:0] mcand;
    logic signed [XLEN:0] mplier;
    logic [XLEN-1:0]   dividend_mag;
    logic [XLEN-1:0]   divisor_mag;
    logic              quot_neg;
    logic              rem_neg;

    muldiv_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .funct3_i       (funct3_i),
        .divisor_zero_i (divisor_zero),
        .last_i         (last),
        .op_o           (op_dec),
        .step_o         (step),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    iter_counter u_cnt (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .step_i (step),
        .last_o (last)
    );

    operand_regs u_opr (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .step_i         (step),
        .op_i           (op_dec),
        .src1_i         (src1_i),
        .src2_i         (src2_i),
        .op_o           (op_reg),
        .mcand_o        (mcand),
        .mplier_o       (mplier),
        .dividend_mag_o (dividend_mag),
        .divisor_mag_o  (divisor_mag),
        .divisor_zero_o (divisor_zero),
        .quot_neg_o     (quot_neg),
        .rem_neg_o      (rem_neg)
    );

    muldiv_acc u_acc (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .step_i         (step),
        .op_i           (op_reg),
        .mcand_i        (mcand),
        .mplier_i       (mplier),
        .dividend_mag_i (dividend_mag),
        .divisor_mag_i  (divisor_mag),
        .quot_neg_i     (quot_neg),
        .rem_neg_i      (rem_neg),
        .rslt_o         (rslt_o)
    );

endmodule

// File: testbench/muldiv_assert.sv
//--------------------------------------------------------------------
// Protocol assertions for the multiply/divide unit.
// Bound into every muldiv_unit instance, watches the done pulse,
// the busy level, the idle result and the length of the divide loop.
//--------------------------------------------------------------------
`timescale 1ns/10ps

module muldiv_assert (
    input logic                        clk_i,
    input logic                        rst_i,
    input logic                        busy_i,
    input logic                        done_i,
    input logic [muldiv_pkg::XLEN-1:0] rslt_i,
    input muldiv_pkg::state_t          state_i
);
    import muldiv_pkg::*;

    int fail_count = 0;     // Failed assertions so far

    done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |=> !done_i)
        else begin
            $error("done_o stayed high for more than one cycle");
            fail_count++;
        end

    done_in_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |-> busy_i)
        else begin
            $error("done_o high while busy_o is low");
            fail_count++;
        end

    rslt_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        !done_i |-> (rslt_i == '0))
        else begin
            $error("rslt_o not zero outside the done cycle");
            fail_count++;
        end

    // One quotient bit per loop cycle, then the return cycle
    exec_len: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(state_i == ST_EXEC) |-> ##DIV_ITERS done_i)
        else begin
            $error("divide loop did not end after the expected number of steps");
            fail_count++;
        end

endmodule

bind muldiv_unit muldiv_assert u_assert (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .busy_i  (busy_o),
    .done_i  (done_o),
    .rslt_i  (rslt_o),
    .state_i (u_ctrl.state_q)
);

// File: testbench/tb_muldiv_unit.sv
//--------------------------------------------------------------------
// Testbench for the RV32M multiply/divide unit.
// Runs a table of edge cases, a start pulse while busy and a set of
// seeded random operations, and checks each result and its latency
// against a model of the M-extension rules.
//--------------------------------------------------------------------
`timescale 1ns/10ps

module tb_muldiv_unit;
    import muldiv_pkg::*;

    localparam int N_RANDOM  = 40;
    localparam int MAX_WAIT  = 60;      // Cycles allowed before done_o is missing
    localparam int WATCH     = 40;      // Quiet cycles after an ignored start
    localparam int DRIVE_DLY = 1;       // ns after the rising edge

    typedef struct packed {
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp;
    } case_t;

    logic            clk_i = 1'b0;
    logic            rst_i;
    logic            start_i;
    logic [2:0]      funct3_i;
    logic [XLEN-1:0] src1_i;
    logic [XLEN-1:0] src2_i;
    logic            busy_o;
    logic            done_o;
    logic [XLEN-1:0] rslt_o;

    case_t  cases[$];
    integer seed        = 32'h2e2a_4504;
    int     errors      = 0;
    int     checks      = 0;
    int     cycle_count = 0;
    int     cycle_limit = 100;          // Raised once the case list is known

    muldiv_unit uut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start_i),
        .funct3_i (funct3_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .rslt_o   (rslt_o)
    );

    always #2 clk_i = ~clk_i;           // 4 ns period

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    //----------------------------------------------------------------
    // Reference model of the M-extension rules
    //----------------------------------------------------------------
    function automatic logic [XLEN-1:0] ref_result(input logic [2:0] f3,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        p;
        int                 ia;
        int                 ib;
        int                 q;
        int                 r;
        logic               ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        ua  = {32'h0, a};
        ub  = {32'h0, b};
        ia  = a;
        ib  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);  // Most negative by -1
        if (b != '0 && !ovf) begin
            q = ia / ib;                // Signed, truncates toward zero
            r = ia % ib;
        end else begin
            q = 0;
            r = 0;
        end
        case (f3)
            F3_MUL:    p = ua * ub;
            F3_MULH:   p = sa * sb;
            F3_MULHSU: p = sa * $signed(ub);
            F3_MULHU:  p = ua * ub;
            default:   p = '0;
        endcase
        case (f3)
            F3_MUL:  return p[31:0];
            F3_DIV:  return (b == '0) ? '1 : (ovf ? a : q);
            F3_DIVU: return (b == '0) ? '1 : a / b;
            F3_REM:  return (b == '0) ? a : (ovf ? '0 : r);
            F3_REMU: return (b == '0) ? a : a % b;
            default: return p[63:32];   // High-half multiplies
        endcase
    endfunction

    function automatic int exp_latency(input logic [2:0] f3, input logic [XLEN-1:0] b);
        if (f3 < F3_DIV || b == '0) begin
            return 2;                   // Capture then product, or zero divisor
        end
        return DIV_ITERS + 2;           // Check, iterations, return
    endfunction

    //----------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------
    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic add_case(input logic [2:0] f3, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp);
        cases.push_back(case_t'{f3, a, b, exp});
    endtask

    task automatic load_cases();
        add_case(F3_MUL,    32'h0000_0007, 32'h0000_0006, 32'h0000_002a);
        add_case(F3_MUL,    32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
        add_case(F3_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_case(F3_MULH,   32'hffff_ffff, 32'h0000_0002, 32'hffff_ffff);
        add_case(F3_MULH,   32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff);
        add_case(F3_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
        add_case(F3_MULHSU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_case(F3_MULHSU, 32'h0000_0002, 32'hffff_ffff, 32'h0000_0001);
        add_case(F3_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
        add_case(F3_MULHU,  32'h0001_0000, 32'h0001_0000, 32'h0000_0001);
        add_case(F3_DIV,    32'h0000_0014, 32'h0000_0003, 32'h0000_0006);
        add_case(F3_DIV,    32'hffff_ffec, 32'h0000_0003, 32'hffff_fffa);
        add_case(F3_DIV,    32'h0000_0014, 32'hffff_fffd, 32'hffff_fffa);
        add_case(F3_DIV,    32'hffff_ffec, 32'hffff_fffd, 32'h0000_0006);
        add_case(F3_DIV,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_case(F3_DIV,    32'h0000_0005, 32'h0000_0000, 32'hffff_ffff);
        add_case(F3_DIVU,   32'hffff_ffec, 32'h0000_0003, 32'h5555_554e);
        add_case(F3_DIVU,   32'h0000_0007, 32'h0000_0000, 32'hffff_ffff);
        add_case(F3_REM,    32'hffff_ffec, 32'h0000_0003, 32'hffff_fffe);
        add_case(F3_REM,    32'h0000_0014, 32'hffff_fffd, 32'h0000_0002);
        add_case(F3_REM,    32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
        add_case(F3_REM,    32'hffff_ffec, 32'h0000_0000, 32'hffff_ffec);
        add_case(F3_REMU,   32'hffff_ffec, 32'h0000_0003, 32'h0000_0002);
        add_case(F3_REMU,   32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
    endtask

    // One operation from start to done, optionally with a start pulse mid-run
    task automatic run_op(input case_t c, input bit poke);
        int              cycles;
        bit              seen;
        logic [XLEN-1:0] got;
        cycles = 0;
        seen   = 1'b0;
        got    = '0;
        while (busy_o) begin
            next_cycle();
        end
        start_i  = 1'b1;
        funct3_i = c.f3;
        src1_i   = c.a;
        src2_i   = c.b;
        while (!seen && cycles < MAX_WAIT) begin
            next_cycle();
            cycles++;
            start_i = 1'b0;
            if (poke && cycles == 5) begin
                start_i  = 1'b1;        // Lands in the divide loop
                funct3_i = F3_MULHU;
                src1_i   = ~c.a;
                src2_i   = ~c.b;
            end
            if (done_o) begin
                seen = 1'b1;
                got  = rslt_o;
            end else if (!busy_o) begin
                $display("busy_o dropped before done_o for funct3 %0d", c.f3);
                errors++;
                cycles = MAX_WAIT;
            end
        end
        if (!seen) begin
            $display("done_o never arrived for funct3 %0d", c.f3);
            errors++;
        end else begin
            check_value("rslt_o", got, c.exp);
            check_value("latency", cycles, exp_latency(c.f3, c.b));
        end
        if (poke) begin
            repeat (WATCH) begin
                next_cycle();
                if (done_o) begin
                    $display("Extra done_o pulse after a start while busy");
                    errors++;
                end
            end
        end
    endtask

    //----------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------
    initial begin
        case_t rc;
        int    mode;
        rst_i    = 1'b1;
        start_i  = 1'b0;
        funct3_i = '0;
        src1_i   = '0;
        src2_i   = '0;
        load_cases();
        cycle_limit = (cases.size() + N_RANDOM + 2) * 40 + 100;  // Poke case counts twice
        repeat (5) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b0;
        check_value("busy_o", busy_o, '0);
        check_value("done_o", done_o, '0);
        check_value("rslt_o", rslt_o, '0);

        foreach (cases[i]) begin
            run_op(cases[i], 1'b0);
        end

        rc = case_t'{F3_DIV, 32'd100, 32'd7, 32'd14};
        run_op(rc, 1'b1);

        repeat (N_RANDOM) begin
            rc.f3 = 3'($random(seed));
            rc.a  = $random(seed);
            rc.b  = $random(seed);
            mode  = $random(seed) & 3;
            if (mode == 0) begin
                rc.b = '0;
            end else if (mode == 1) begin
                rc.b = rc.b & 32'h0000_00ff;    // Small divisors give long quotients
            end
            rc.exp = ref_result(rc.f3, rc.a, rc.b);
            run_op(rc, 1'b0);
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.u_assert.fail_count);
        if (errors == 0 && uut.u_assert.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: muldiv_unit.f
common/muldiv_pkg.sv
hw/muldiv/muldiv_ctrl.sv
hw/muldiv/iter_counter.sv
hw/muldiv/operand_regs.sv
hw/muldiv/muldiv_acc.sv
hw/muldiv/muldiv_unit.sv
testbench/muldiv_assert.sv
testbench/tb_muldiv_unit.sv

// File: Bender.yml
package:
  name: muldiv_unit

sources:
  - common/muldiv_pkg.sv
  - hw/muldiv/muldiv_ctrl.sv
  - hw/muldiv/iter_counter.sv
  - hw/muldiv/operand_regs.sv
  - hw/muldiv/muldiv_acc.sv
  - hw/muldiv/muldiv_unit.sv
  - target: test
    files:
      - testbench/muldiv_assert.sv
      - testbench/tb_muldiv_unit.sv
